// File: strOpPkg.sv
package strOpPkg;

   // command opcodes, codes 5 to 7 are not defined.
   typedef enum logic [2:0] {
      OP_EQUAL      = 3'd0,
      OP_FIRST_DIFF = 3'd1,
      OP_ORDER      = 3'd2,
      OP_LENGTH     = 3'd3,
      OP_PREFIX     = 3'd4
   } opcode_e;

   typedef struct packed {
      opcode_e      opcode;
      logic [3:0]   tag;
      logic [127:0] strA;   // byte 0 in bits 7:0.
      logic [127:0] strB;
   } cmd_t;

   // result selection in the last stage.
   typedef enum logic [2:0] {
      SEL_EQUAL,
      SEL_FIRST_DIFF,
      SEL_ORDER,
      SEL_LENGTH,
      SEL_PREFIX,
      SEL_ILLEGAL
   } resSel_e;

   typedef struct packed {
      resSel_e      resSel;
      logic         nullNeverMatches;   // zero B byte forces a mismatch.
      logic [3:0]   tag;
      logic [127:0] strA;
      logic [127:0] strB;
   } ctrl_t;

endpackage

// File: strResPkg.sv
package strResPkg;

   // one bit per byte position.
   typedef struct packed {
      logic [15:0]       mismatch;
      logic [15:0]       lessA;
      logic [15:0]       nzA;
      logic [15:0]       nzB;
      strOpPkg::resSel_e resSel;
      logic [3:0]        tag;
   } cmpVec_t;

   typedef enum logic {
      ST_OK      = 1'b0,
      ST_ILLEGAL = 1'b1
   } status_e;

   typedef struct packed {
      logic [3:0] tag;
      status_e    status;
      logic [7:0] value;
   } res_t;

endpackage

// File: strDecode.sv
`timescale 1ns/1ps

module strDecode (
   input  logic             clk,
   input  logic             rst,
   input  logic             i_cmdValid,
   input  strOpPkg::cmd_t   i_cmd,
   output logic             o_ctrlValid,
   output strOpPkg::ctrl_t  o_ctrl
);

   strOpPkg::resSel_e resSel;
   logic              nullNeverMatches;

   always_comb begin
      nullNeverMatches = 1'b0;
      case (i_cmd.opcode)
         strOpPkg::OP_EQUAL:      resSel = strOpPkg::SEL_EQUAL;
         strOpPkg::OP_FIRST_DIFF: resSel = strOpPkg::SEL_FIRST_DIFF;
         strOpPkg::OP_ORDER:      resSel = strOpPkg::SEL_ORDER;
         strOpPkg::OP_LENGTH:     resSel = strOpPkg::SEL_LENGTH;
         strOpPkg::OP_PREFIX: begin
            resSel           = strOpPkg::SEL_PREFIX;
            nullNeverMatches = 1'b1;   // end of B must not count as a match.
         end
         default:                 resSel = strOpPkg::SEL_ILLEGAL;
      endcase
   end

   // one cycle valid pulse per accepted command.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         o_ctrlValid <= 1'b0;
      end else begin
         o_ctrlValid <= i_cmdValid;
      end
   end

   always_ff @(posedge clk) begin
      if (i_cmdValid) begin
         o_ctrl.resSel           <= resSel;
         o_ctrl.nullNeverMatches <= nullNeverMatches;
         o_ctrl.tag              <= i_cmd.tag;
         o_ctrl.strA             <= i_cmd.strA;
         o_ctrl.strB             <= i_cmd.strB;
      end
   end

endmodule

// File: strCompare.sv
`timescale 1ns/1ps

module strCompare (
   input  logic               clk,
   input  logic               rst,
   input  logic               i_ctrlValid,
   input  strOpPkg::ctrl_t    i_ctrl,
   output logic               o_cmpValid,
   output strResPkg::cmpVec_t o_cmp
);

   logic [127:0] effA;
   logic [127:0] effB;
   logic [15:0]  mismatch;
   logic [15:0]  lessA;
   logic [15:0]  nzA;
   logic [15:0]  nzB;

   // effective strings, everything past the first zero reads as zero.
   always_comb begin
      logic liveA;
      logic liveB;
      liveA = 1'b1;
      liveB = 1'b1;
      for (int i = 0; i < 16; i++) begin
         effA[i*8 +: 8] = liveA ? i_ctrl.strA[i*8 +: 8] : 8'h00;
         effB[i*8 +: 8] = liveB ? i_ctrl.strB[i*8 +: 8] : 8'h00;
         liveA = liveA && (i_ctrl.strA[i*8 +: 8] != 8'h00);
         liveB = liveB && (i_ctrl.strB[i*8 +: 8] != 8'h00);
      end
   end

   always_comb begin
      for (int i = 0; i < 16; i++) begin
         nzA[i]      = |effA[i*8 +: 8];
         nzB[i]      = |effB[i*8 +: 8];
         lessA[i]    = effA[i*8 +: 8] < effB[i*8 +: 8];
         mismatch[i] = (effA[i*8 +: 8] != effB[i*8 +: 8]) ||
                       (i_ctrl.nullNeverMatches && !nzB[i]);
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         o_cmpValid <= 1'b0;
      end else begin
         o_cmpValid <= i_ctrlValid;
      end
   end

   always_ff @(posedge clk) begin
      if (i_ctrlValid) begin
         o_cmp.mismatch <= mismatch;
         o_cmp.lessA    <= lessA;
         o_cmp.nzA      <= nzA;
         o_cmp.nzB      <= nzB;
         o_cmp.resSel   <= i_ctrl.resSel;
         o_cmp.tag      <= i_ctrl.tag;
      end
   end

endmodule

// File: strResult.sv
`timescale 1ns/1ps

module strResult #(
   parameter int DEPTH       = 4,
   parameter int OUT_CREDITS = 2
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               i_cmpValid,
   input  strResPkg::cmpVec_t i_cmp,
   input  logic               i_resCredit,
   output logic               o_resValid,
   output strResPkg::res_t    o_res,
   output logic               o_cmdCredit
);

   localparam int ptrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int cntW = $clog2(DEPTH + 1);
   localparam int crdW = (OUT_CREDITS > 0) ? $clog2(OUT_CREDITS + 1) : 1;

   strResPkg::res_t mem [DEPTH];
   strResPkg::res_t pushRes;
   logic [ptrW-1:0] wrPtr;
   logic [ptrW-1:0] rdPtr;
   logic [cntW-1:0] fifoCount;
   logic [crdW-1:0] outCredits;
   logic [4:0]      firstDiff;
   logic [4:0]      lenA;
   logic [4:0]      lenB;
   logic            lessAtDiff;
   logic            pop;

   always_comb begin
      firstDiff = 5'd16;   // no difference.
      lenA      = '0;
      lenB      = '0;
      for (int i = 15; i >= 0; i--) begin
         if (i_cmp.mismatch[i]) firstDiff = 5'(i);
      end
      for (int i = 0; i < 16; i++) begin
         lenA = lenA + 5'(i_cmp.nzA[i]);
         lenB = lenB + 5'(i_cmp.nzB[i]);
      end
      lessAtDiff = !firstDiff[4] && i_cmp.lessA[firstDiff[3:0]];
   end

   always_comb begin
      pushRes.tag    = i_cmp.tag;
      pushRes.status = strResPkg::ST_OK;
      case (i_cmp.resSel)
         strOpPkg::SEL_EQUAL:      pushRes.value = {7'd0, ~|i_cmp.mismatch};
         strOpPkg::SEL_FIRST_DIFF: pushRes.value = {3'd0, firstDiff};
         strOpPkg::SEL_ORDER:      pushRes.value = firstDiff[4] ? 8'd0 : (lessAtDiff ? 8'd1 : 8'd2);
         strOpPkg::SEL_LENGTH:     pushRes.value = {3'd0, lenA};
         strOpPkg::SEL_PREFIX:     pushRes.value = {7'd0, firstDiff == lenB};
         default: begin
            pushRes.status = strResPkg::ST_ILLEGAL;
            pushRes.value  = 8'd0;
         end
      endcase
   end

   assign pop = (fifoCount != '0) && (outCredits != '0);

   always_ff @(posedge clk) begin
      if (i_cmpValid) mem[wrPtr] <= pushRes;
      if (pop) o_res <= mem[rdPtr];
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wrPtr       <= '0;
         rdPtr       <= '0;
         fifoCount   <= '0;
         outCredits  <= crdW'(OUT_CREDITS);
         o_resValid  <= 1'b0;
         o_cmdCredit <= 1'b0;
      end else begin
         o_resValid  <= pop;
         o_cmdCredit <= pop;   // slot freed, upstream may send again.
         if (i_cmpValid) wrPtr <= (wrPtr == ptrW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
         if (pop) rdPtr <= (rdPtr == ptrW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
         case ({i_cmpValid, pop})
            2'b10:   fifoCount <= fifoCount + 1'b1;
            2'b01:   fifoCount <= fifoCount - 1'b1;
            default: ;
         endcase
         case ({pop, i_resCredit})
            2'b10:   outCredits <= outCredits - 1'b1;
            2'b01:   outCredits <= outCredits + 1'b1;
            default: ;
         endcase
      end
   end

endmodule

// File: strMatchTop.sv
`timescale 1ns/1ps

module strMatchTop #(
   parameter int DEPTH       = 4,
   parameter int OUT_CREDITS = 2
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            i_cmdValid,
   input  strOpPkg::cmd_t  i_cmd,
   output logic            o_cmdCredit,
   input  logic            i_resCredit,
   output logic            o_resValid,
   output strResPkg::res_t o_res
);

   logic               ctrlValid;
   strOpPkg::ctrl_t    ctrl;
   logic               cmpValid;
   strResPkg::cmpVec_t cmp;

   strDecode strDecode_inst (
      .clk         (clk),
      .rst         (rst),
      .i_cmdValid  (i_cmdValid),
      .i_cmd       (i_cmd),
      .o_ctrlValid (ctrlValid),
      .o_ctrl      (ctrl)
   );

   strCompare strCompare_inst (
      .clk         (clk),
      .rst         (rst),
      .i_ctrlValid (ctrlValid),
      .i_ctrl      (ctrl),
      .o_cmpValid  (cmpValid),
      .o_cmp       (cmp)
   );

   // fifo depth matches the upstream credit count.
   strResult #(
      .DEPTH       (DEPTH),
      .OUT_CREDITS (OUT_CREDITS)
   ) strResult_inst (
      .clk         (clk),
      .rst         (rst),
      .i_cmpValid  (cmpValid),
      .i_cmp       (cmp),
      .i_resCredit (i_resCredit),
      .o_resValid  (o_resValid),
      .o_res       (o_res),
      .o_cmdCredit (o_cmdCredit)
   );

endmodule

// File: strMatch_asserts.sv
`timescale 1ns/1ps

module strMatch_asserts #(
   parameter int DEPTH = 4,
   parameter int cntW  = 3,
   parameter int crdW  = 2
) (
   input logic            clk,
   input logic            rst,
   input logic            i_resValid,
   input logic            i_cmdCredit,
   input logic [cntW-1:0] i_fifoCount,
   input logic [crdW-1:0] i_outCredits
);

   // a result may only leave on a held credit.
   resNeedsCredit: assert property (@(posedge clk) disable iff (rst)
      i_resValid |-> $past(i_outCredits) != '0)
      else $error("result sent with no downstream credit");

   fifoBound: assert property (@(posedge clk) disable iff (rst)
      i_fifoCount <= cntW'(DEPTH))
      else $error("result FIFO holds more than DEPTH entries");

   creditWithResult: assert property (@(posedge clk) disable iff (rst)
      i_cmdCredit == i_resValid)
      else $error("input credit not paired with a result");

endmodule

bind strResult strMatch_asserts #(
   .DEPTH (DEPTH),
   .cntW  (cntW),
   .crdW  (crdW)
) strMatch_asserts_inst (
   .clk          (clk),
   .rst          (rst),
   .i_resValid   (o_resValid),
   .i_cmdCredit  (o_cmdCredit),
   .i_fifoCount  (fifoCount),
   .i_outCredits (outCredits)
);

// File: strMatchTb.sv
`timescale 1ns/1ps

module strMatchTb;

   localparam int DEPTH       = 4;
   localparam int OUT_CREDITS = 2;
   localparam int maxVec      = 64;

   typedef struct packed {
      logic [3:0] test;
      logic [3:0] tag;
      logic       status;
      logic [7:0] value;
   } expRes_t;

   logic            clk;
   logic            rst;
   logic            i_cmdValid;
   strOpPkg::cmd_t  i_cmd;
   logic            o_cmdCredit;
   logic            i_resCredit;
   logic            o_resValid;
   strResPkg::res_t o_res;

   int           nVec;
   logic [3:0]   vTest [maxVec];
   logic [2:0]   vOp   [maxVec];
   logic [3:0]   vTag  [maxVec];
   logic [127:0] vA    [maxVec];
   logic [127:0] vB    [maxVec];
   logic         vSt   [maxVec];
   logic [7:0]   vVal  [maxVec];
   expRes_t      expQ [$];
   int           target [16];
   int           doneCnt [16];
   int           testErrs [16];
   int           sent;
   int           creditsBack;
   int           gotTotal;
   int           returned;
   int           checks;
   int           errCnt;
   int           mainErrs;
   int           creditMode;   // 0 hold, 1 random, 2 release.
   logic [31:0]  lfsr;
   bit           loaded;

   strMatchTop #(
      .DEPTH       (DEPTH),
      .OUT_CREDITS (OUT_CREDITS)
   ) strMatchTop_inst (
      .clk         (clk),
      .rst         (rst),
      .i_cmdValid  (i_cmdValid),
      .i_cmd       (i_cmd),
      .o_cmdCredit (o_cmdCredit),
      .i_resCredit (i_resCredit),
      .o_resValid  (o_resValid),
      .o_res       (o_res)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // taps 32, 22, 2, 1.
   function automatic logic nextBit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic int inputCredits();
      return DEPTH - sent + creditsBack;
   endfunction

   // downstream consumer, returns one credit per result it has taken.
   initial begin
      lfsr        = 32'h3775;
      returned    = 0;
      i_resCredit = 1'b0;
      forever begin
         @(negedge clk);
         if (rst) begin
            i_resCredit = 1'b0;
         end else if (gotTotal > returned &&
                      (creditMode == 2 || (creditMode == 1 && nextBit()))) begin
            i_resCredit = 1'b1;
            returned++;
         end else begin
            i_resCredit = 1'b0;
         end
      end
   end

   // outputs are read at the rising edge, one cycle after they were set.
   initial begin
      expRes_t e;
      int      bad;
      creditsBack = 0;
      gotTotal    = 0;
      checks      = 0;
      errCnt      = 0;
      for (int i = 0; i < 16; i++) begin
         doneCnt[i]  = 0;
         testErrs[i] = 0;
      end
      forever begin
         @(posedge clk);
         if (!rst) begin
            if (o_cmdCredit) begin
               creditsBack++;
               if (inputCredits() > DEPTH) begin
                  $display("input credit count rose above %0d at %0t", DEPTH, $time);
                  errCnt++;
               end
            end
            if (o_resValid) begin
               gotTotal++;
               if (expQ.size() == 0) begin
                  $display("extra result with tag %0h at %0t", o_res.tag, $time);
                  errCnt++;
               end else begin
                  e   = expQ.pop_front();
                  bad = 0;
                  checks++;
                  if (o_res.tag !== e.tag) begin
                     $display("ERR %0t o_res.tag expected %0h got %0h",
                              $time, e.tag, o_res.tag);
                     bad++;
                  end
                  if (o_res.status !== e.status) begin
                     $display("ERR %0t o_res.status expected %0h got %0h",
                              $time, e.status, o_res.status);
                     bad++;
                  end
                  if (o_res.value !== e.value) begin
                     $display("ERR %0t o_res.value expected %0h got %0h",
                              $time, e.value, o_res.value);
                     bad++;
                  end
                  errCnt += bad;
                  testErrs[e.test] += bad;
                  doneCnt[e.test]++;
                  if (doneCnt[e.test] == target[e.test]) begin
                     $display("test %0d done, %0d results, %0d errors",
                              e.test, doneCnt[e.test], testErrs[e.test]);
                  end
               end
            end
         end
      end
   end

   task automatic sendVec(input int idx, input logic [3:0] test);
      expRes_t e;
      @(negedge clk);
      while (inputCredits() <= 0) @(negedge clk);
      i_cmd.opcode = strOpPkg::opcode_e'(vOp[idx]);
      i_cmd.tag    = vTag[idx];
      i_cmd.strA   = vA[idx];
      i_cmd.strB   = vB[idx];
      i_cmdValid   = 1'b1;
      sent++;
      e.test   = test;
      e.tag    = vTag[idx];
      e.status = vSt[idx];
      e.value  = vVal[idx];
      expQ.push_back(e);
      @(negedge clk);
      i_cmdValid = 1'b0;
   endtask

   task automatic waitDrain(input int limit);
      int n;
      n = 0;
      while (expQ.size() != 0 && n < limit) begin
         @(posedge clk);
         n++;
      end
      if (expQ.size() != 0) begin
         $display("missing result, %0d results never arrived", expQ.size());
         mainErrs++;
         expQ.delete();
      end
   endtask

   task automatic waitReturns(input int limit);
      int n;
      n = 0;
      while ((gotTotal != returned || inputCredits() != DEPTH) && n < limit) begin
         @(posedge clk);
         n++;
      end
   endtask

   initial begin
      wait (loaded);
      repeat (nVec * 40 + 500) @(posedge clk);
      $display("watchdog expired before the tests finished");
      $display("Some tests failed");
      $finish;
   end

   initial begin
      int           fd;
      int           n;
      int           got0;
      int           back0;
      string        line;
      logic [3:0]   tst;
      logic [2:0]   op;
      logic [3:0]   tag;
      logic [127:0] a;
      logic [127:0] b;
      logic         st;
      logic [7:0]   val;
      rst        = 1'b1;
      i_cmdValid = 1'b0;
      i_cmd      = '0;
      sent       = 0;
      mainErrs   = 0;
      creditMode = 0;
      nVec       = 0;
      loaded     = 1'b0;
      for (int i = 0; i < 16; i++) target[i] = 0;
      fd = $fopen("strMatchVectors.txt", "r");
      if (fd == 0) begin
         $display("cannot open strMatchVectors.txt");
         $display("Some tests failed");
         $finish;
      end else begin
         while (!$feof(fd) && nVec < maxVec) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != "#") begin
               n = $sscanf(line, "%h %h %h %h %h %h %h", tst, op, tag, a, b, st, val);
               if (n == 7) begin
                  vTest[nVec] = tst;
                  vOp[nVec]   = op;
                  vTag[nVec]  = tag;
                  vA[nVec]    = a;
                  vB[nVec]    = b;
                  vSt[nVec]   = st;
                  vVal[nVec]  = val;
                  target[tst]++;
                  nVec++;
               end
            end
         end
         $fclose(fd);
         loaded = 1'b1;
         repeat (8) @(posedge clk);
         @(negedge clk);
         rst = 1'b0;

         // back-pressure, first use up the downstream credits.
         target[5] = OUT_CREDITS + DEPTH;
         for (int i = 0; i < OUT_CREDITS; i++) sendVec(i, 4'd5);
         waitDrain(200);
         got0  = gotTotal;
         back0 = creditsBack;
         for (int i = OUT_CREDITS; i < OUT_CREDITS + DEPTH; i++) sendVec(i, 4'd5);
         repeat (20) @(negedge clk);
         if (gotTotal != got0) begin
            $display("result appeared while downstream credits were withheld");
            mainErrs++;
         end
         if (creditsBack != back0) begin
            $display("input credit returned while results were held");
            mainErrs++;
         end
         @(posedge clk);
         creditMode = 2;
         waitDrain(200);
         waitReturns(200);

         // random credit timing over every vector.
         @(posedge clk);
         creditMode = 1;
         for (int i = 0; i < nVec; i++) sendVec(i, vTest[i]);
         waitDrain(nVec * 20 + 200);
         @(posedge clk);
         creditMode = 2;
         waitReturns(200);
         if (inputCredits() != DEPTH) begin
            $display("input credits ended at %0d instead of %0d", inputCredits(), DEPTH);
            mainErrs++;
         end
         $display("test 6 done, %0d vectors, input credits %0d", nVec, inputCredits());

         $display("summary: %0d checks, %0d errors", checks, errCnt + mainErrs);
         if (errCnt + mainErrs == 0) begin
            $display("All tests passed");
         end else begin
            $display("Some tests failed");
         end
         $finish;
      end
   end

endmodule

// File: strMatchVectors.txt
# test opcode tag strA strB status value, all hex
# byte 0 of a string is its rightmost byte
1 0 0 636261 636261 0 01
1 0 1 636261 646261 0 00
1 1 2 636261 636278 0 00
1 1 3 636261 636261 0 10
1 1 4 61616161616161616161616161616161 62616161616161616161616161616161 0 0f
1 2 5 636261 646261 0 01
1 2 6 646261 636261 0 02
1 2 7 636261 636261 0 00
1 2 8 6261 636261 0 01
1 3 9 636261 0 0 03
1 3 a 61616161616161616161616161616161 0 0 10
1 3 b 0 636261 0 00
2 0 c 78006261 79006261 0 01
2 3 d 78006261 0 0 02
2 1 e 78006261 79006261 0 10
2 2 f 65006261 61006261 0 00
3 4 0 64636261 6261 0 01
3 4 1 6261 636261 0 00
3 4 2 64636261 7861 0 00
3 4 3 636261 0 0 01
3 4 4 636261 636261 0 01
3 4 5 61616161616161616161616161616161 61616161616161616161616161616161 0 01
4 5 6 636261 636261 1 00
4 6 7 636261 0 1 00
4 7 8 0 0 1 00
4 0 9 636261 636261 0 01

// File: compile.f
strOpPkg.sv
strResPkg.sv
strDecode.sv
strCompare.sv
strResult.sv
strMatchTop.sv
strMatch_asserts.sv
strMatchTb.sv

// File: run.sh
#!/bin/sh
# build and run the string compare testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module strMatchTb -o strMatchSim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/strMatchSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^All tests passed$" sim.log; then
   exit 0
fi
exit 1
